// File: build.f
xv_pkg.sv
copper_mem.sv
video_timing.sv
host_port.sv
copper_engine.sv
copper_top.sv
tb_copper_top.sv

// File: copper_engine.sv
/*
  Copper execution engine.
  Restarts at address 0 the cycle after frame_start_i when enabled,
  and idles at that point otherwise. Instruction fetch takes two
  cycles, FETCH presents the address and DECODE sees the word.
  WAITV and WAITH hold until the raster count reaches the target,
  MOVE reads its data word and pulses reg_wr_o, JUMP reloads the
  program counter, END idles until the next frame.
*/
module copper_engine #(
    parameter int AWIDTH = 10
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          copp_en_i,
    input  logic                          frame_start_i,
    input  logic [xv_pkg::HPOS_W-1:0]     h_count_i,
    input  logic [xv_pkg::VPOS_W-1:0]     v_count_i,
    output logic [AWIDTH-1:0]             mem_rd_addr_o,
    input  xv_pkg::word_t                 mem_rd_data_i,
    output logic                          reg_wr_o,
    output logic [xv_pkg::MOVE_REG_W-1:0] reg_addr_o,
    output xv_pkg::word_t                 reg_data_o
);
    import xv_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_WAIT,
        ST_MOVE_DATA,
        ST_WRITE
    } state_t;

    state_t            state;
    logic [AWIDTH-1:0] pc;
    // latched instruction, operands for WAIT and MOVE
    word_t             ir;
    copp_op_t          op;
    logic              decode_hit;
    logic              wait_hit;

    // memory always reads at the program counter
    assign mem_rd_addr_o = pc;

    // opcode of the word arriving in DECODE
    assign op = copp_op_t'(mem_rd_data_i[OP_MSB:OP_LSB]);

    // wait compare for the word being decoded
    // lets an already met wait skip the WAIT state
    always_comb begin
        if (op == OP_WAITV) begin
            decode_hit = (v_count_i >= VPOS_W'(mem_rd_data_i[WAIT_W-1:0]));
        end else begin
            decode_hit = (h_count_i >= HPOS_W'(mem_rd_data_i[WAIT_W-1:0]));
        end
    end

    // wait compare against the latched instruction
    always_comb begin
        if (copp_op_t'(ir[OP_MSB:OP_LSB]) == OP_WAITV) begin
            wait_hit = (v_count_i >= VPOS_W'(ir[WAIT_W-1:0]));
        end else begin
            // WAITH, horizontal position within the current line
            wait_hit = (h_count_i >= HPOS_W'(ir[WAIT_W-1:0]));
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= ST_IDLE;
            pc    <= '0;
        end else if (frame_start_i) begin
            // new frame overrides whatever was running
            // enable is sampled only here
            if (copp_en_i) begin
                pc    <= '0;
                state <= ST_FETCH;
            end else begin
                state <= ST_IDLE;
            end
        end else begin
            case (state)
                ST_IDLE: ;
                // address out, word arrives next cycle
                ST_FETCH: state <= ST_DECODE;
                ST_DECODE: begin
                    case (op)
                        OP_WAITV, OP_WAITH: begin
                            pc <= pc + 1'b1;
                            if (decode_hit) begin
                                state <= ST_FETCH;
                            end else begin
                                state <= ST_WAIT;
                            end
                        end
                        OP_MOVE: begin
                            // point at the data word
                            pc    <= pc + 1'b1;
                            state <= ST_MOVE_DATA;
                        end
                        OP_JUMP: begin
                            pc    <= AWIDTH'(mem_rd_data_i[JUMP_W-1:0]);
                            state <= ST_FETCH;
                        end
                        // END and undefined opcodes stop the program
                        default: state <= ST_IDLE;
                    endcase
                end
                ST_WAIT: begin
                    if (wait_hit) begin
                        state <= ST_FETCH;
                    end
                end
                // data word read is in flight
                ST_MOVE_DATA: state <= ST_WRITE;
                ST_WRITE: begin
                    pc    <= pc + 1'b1;
                    state <= ST_FETCH;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // latch the instruction as it is decoded
    always_ff @(posedge clk) begin
        if (state == ST_DECODE) begin
            ir <= mem_rd_data_i;
        end
    end

    // register write pulse, the cycle after the data word arrives
    always_ff @(posedge clk) begin
        if (rst_i) begin
            reg_wr_o <= 1'b0;
        end else begin
            reg_wr_o <= (state == ST_WRITE);
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_WRITE) begin
            reg_addr_o <= ir[MOVE_REG_W-1:0];
            reg_data_o <= mem_rd_data_i;
        end
    end

endmodule

// File: copper_mem.sv
/*
  Copper program memory, an inferred block RAM with one registered
  read port for the engine and one write port for the host side.
  Every word starts out as END. With ADDINFO set the top 128 words
  carry the build information block: description string, version,
  git status and git hash. A write to the address being read in the
  same cycle is forwarded to the read data.
*/
module copper_mem #(
    parameter int AWIDTH  = 10,
    parameter bit ADDINFO = 1'b1
) (
    input  logic [AWIDTH-1:0] rd_addr_i,
    output xv_pkg::word_t     rd_data_o,
    input  logic              wr_en_i,
    input  logic [AWIDTH-1:0] wr_addr_i,
    input  xv_pkg::word_t     wr_data_i,
    input  logic              clk
);
    import xv_pkg::*;

    localparam int DEPTH     = 2 ** AWIDTH;
    // first word of the info block
    localparam int INFO_BASE = DEPTH - INFO_WORDS;

    word_t bram [DEPTH];

    // k-th description character, zero once past the end of the string
    function automatic logic [7:0] info_char(input int k);
        if (k < INFO_STR_LEN) begin
            // string literal keeps its first character in the top byte
            return INFO_STR[8*(INFO_STR_LEN-1-k) +: 8];
        end
        return 8'h00;
    endfunction

    initial begin
        // whole memory reads as END until the host loads a program
        for (int i = 0; i < DEPTH; i++) begin
            bram[i] = END_FILL;
        end
        if (ADDINFO) begin
            // two characters per word, earlier one in the high byte
            for (int w = 0; w < INFO_WORDS - 4; w++) begin
                bram[INFO_BASE + w] = {info_char(2*w), info_char(2*w + 1)};
            end
            bram[DEPTH-4] = INFO_VERSION;
            // dirty flag sits in the high byte
            bram[DEPTH-3] = {7'b0, INFO_GIT_DIRTY, 8'h00};
            // hash, high half first
            bram[DEPTH-2] = INFO_GITHASH[31:16];
            bram[DEPTH-1] = INFO_GITHASH[15:0];
        end
    end

    // single clock, write port and registered read port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            bram[wr_addr_i] <= wr_data_i;
        end
        // same-address collision returns the word being written
        if (wr_en_i && (wr_addr_i == rd_addr_i)) begin
            rd_data_o <= wr_data_i;
        end else begin
            rd_data_o <= bram[rd_addr_i];
        end
    end

endmodule

// File: copper_top.sv
/*
  Top level of the copper display-list coprocessor.
  The host loads a program through host_port into copper_mem,
  video_timing provides the raster counts, and copper_engine runs
  the program once per frame, issuing writes on reg_wr_o with
  reg_addr_o and reg_data_o to an external video register file.
*/
module copper_top #(
    parameter int AWIDTH  = 10,
    parameter bit ADDINFO = 1'b1,
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic                          clk,
    input  logic                          rst_i,
    input  logic                          host_wr_i,
    input  logic [1:0]                    host_reg_i,
    input  xv_pkg::word_t                 host_data_i,
    output logic                          reg_wr_o,
    output logic [xv_pkg::MOVE_REG_W-1:0] reg_addr_o,
    output xv_pkg::word_t                 reg_data_o,
    output logic [xv_pkg::HPOS_W-1:0]     h_count_o,
    output logic [xv_pkg::VPOS_W-1:0]     v_count_o
);
    import xv_pkg::*;

    // host side write into copper memory
    logic              mem_wr_en;
    logic [AWIDTH-1:0] mem_wr_addr;
    word_t             mem_wr_data;

    // engine side read
    logic [AWIDTH-1:0] mem_rd_addr;
    word_t             mem_rd_data;

    logic copp_en;
    logic frame_start;

    host_port #(
        .AWIDTH(AWIDTH)
    ) i_host_port (
        .clk          (clk),
        .rst_i        (rst_i),
        .host_wr_i    (host_wr_i),
        .host_reg_i   (host_reg_i),
        .host_data_i  (host_data_i),
        .mem_wr_en_o  (mem_wr_en),
        .mem_wr_addr_o(mem_wr_addr),
        .mem_wr_data_o(mem_wr_data),
        .copp_en_o    (copp_en)
    );

    copper_mem #(
        .AWIDTH (AWIDTH),
        .ADDINFO(ADDINFO)
    ) i_copper_mem (
        .rd_addr_i(mem_rd_addr),
        .rd_data_o(mem_rd_data),
        .wr_en_i  (mem_wr_en),
        .wr_addr_i(mem_wr_addr),
        .wr_data_i(mem_wr_data),
        .clk      (clk)
    );

    // counts go straight to the top outputs and feed the engine
    video_timing #(
        .H_TOTAL(H_TOTAL),
        .V_TOTAL(V_TOTAL)
    ) i_video_timing (
        .clk          (clk),
        .rst_i        (rst_i),
        .h_count_o    (h_count_o),
        .v_count_o    (v_count_o),
        .frame_start_o(frame_start)
    );

    copper_engine #(
        .AWIDTH(AWIDTH)
    ) i_copper_engine (
        .clk          (clk),
        .rst_i        (rst_i),
        .copp_en_i    (copp_en),
        .frame_start_i(frame_start),
        .h_count_i    (h_count_o),
        .v_count_i    (v_count_o),
        .mem_rd_addr_o(mem_rd_addr),
        .mem_rd_data_i(mem_rd_data),
        .reg_wr_o     (reg_wr_o),
        .reg_addr_o   (reg_addr_o),
        .reg_data_o   (reg_data_o)
    );

endmodule

// File: host_port.sv
/*
  Host write port for the copper.
  Three write-only registers, selected by host_reg_i on a one-cycle
  host_wr_i strobe:
    0  copper memory write pointer
    1  copper memory data, written at the pointer which then steps by one
    2  control, bit 0 enables the copper
  Memory writes leave one cycle after the strobe.
*/
module host_port #(
    parameter int AWIDTH = 10
) (
    input  logic                clk,
    input  logic                rst_i,
    input  logic                host_wr_i,
    input  logic [1:0]          host_reg_i,
    input  xv_pkg::word_t       host_data_i,
    output logic                mem_wr_en_o,
    output logic [AWIDTH-1:0]   mem_wr_addr_o,
    output xv_pkg::word_t       mem_wr_data_o,
    output logic                copp_en_o
);

    // host register numbers
    localparam logic [1:0] REG_WR_ADDR = 2'd0;
    localparam logic [1:0] REG_WR_DATA = 2'd1;
    localparam logic [1:0] REG_CTRL    = 2'd2;

    logic [AWIDTH-1:0] wr_ptr;

    // control state
    always_ff @(posedge clk) begin
        if (rst_i) begin
            wr_ptr      <= '0;
            mem_wr_en_o <= 1'b0;
            copp_en_o   <= 1'b0;
        end else begin
            mem_wr_en_o <= 1'b0;
            if (host_wr_i) begin
                case (host_reg_i)
                    REG_WR_ADDR: wr_ptr <= host_data_i[AWIDTH-1:0];
                    REG_WR_DATA: begin
                        mem_wr_en_o <= 1'b1;
                        // step for the next data word
                        wr_ptr      <= wr_ptr + 1'b1;
                    end
                    REG_CTRL: copp_en_o <= host_data_i[0];
                    // register 3 is unused, writes are dropped
                    default: ;
                endcase
            end
        end
    end

    // address and data of the pending memory write
    always_ff @(posedge clk) begin
        if (host_wr_i && (host_reg_i == REG_WR_DATA)) begin
            mem_wr_addr_o <= wr_ptr;
            mem_wr_data_o <= host_data_i;
        end
    end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the copper testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_copper_top -o tb_copper_top
./obj_dir/tb_copper_top 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "PASS: all tests" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// File: tb_copper_top.sv
/*
  Testbench for the copper display-list coprocessor.
  Loads programs through the host port while keeping a shadow copy of
  copper memory, predicts each frame's register writes from the shadow
  program and checks every reg_wr_o pulse against that prediction.
  Covers disabled frames, MOVE lists, raster waits, JUMP into the END
  fill, the build info block and enable changes mid-frame.
*/
module tb_copper_top;
    timeunit 1ns;
    timeprecision 1ps;
    import xv_pkg::*;

    localparam int AWIDTH       = 8;
    localparam int H_TOTAL      = 64;
    localparam int V_TOTAL      = 16;
    localparam int MEM_WORDS    = 2 ** AWIDTH;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 3;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    // slack for program loading and the final checks
    localparam int LOAD_CYCLES  = 256;
    localparam int WATCHDOG_NS  =
        (RESET_CYCLES + 12 * FRAME_CYCLES + LOAD_CYCLES) * CLK_PERIOD;

    // one predicted register write and its raster position window
    typedef struct packed {
        logic [7:0] addr;
        word_t      data;
        int         earliest;
        int         latest;
    } exp_t;

    logic       clk;
    logic       rst_i;
    logic       host_wr_i;
    logic [1:0] host_reg_i;
    word_t      host_data_i;
    logic       reg_wr_o;
    logic [7:0] reg_addr_o;
    word_t      reg_data_o;
    logic [HPOS_W-1:0] h_count_o;
    logic [VPOS_W-1:0] v_count_o;

    word_t       shadow [MEM_WORDS];
    logic [7:0]  wr_ptr;
    logic        en_model;
    exp_t        exp_q [$];
    logic [16:0] lfsr_state = 17'd96126;

    copper_top #(
        .AWIDTH (AWIDTH),
        .ADDINFO(1'b1),
        .H_TOTAL(H_TOTAL),
        .V_TOTAL(V_TOTAL)
    ) i_copper_top (
        .clk        (clk),
        .rst_i      (rst_i),
        .host_wr_i  (host_wr_i),
        .host_reg_i (host_reg_i),
        .host_data_i(host_data_i),
        .reg_wr_o   (reg_wr_o),
        .reg_addr_o (reg_addr_o),
        .reg_data_o (reg_data_o),
        .h_count_o  (h_count_o),
        .v_count_o  (v_count_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // 17 bit fibonacci lfsr with taps 17 and 14
    function automatic logic [16:0] lfsr_next(input logic [16:0] s);
        return {s[15:0], s[16] ^ s[13]};
    endfunction

    // one step per data bit
    function automatic word_t next_rand_word();
        word_t w;
        w = '0;
        for (int i = 0; i < 16; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[14:0], lfsr_state[0]};
        end
        return w;
    endfunction

    // instruction encodings
    function automatic word_t enc_waitv(input int t);
        return {OP_WAITV, 12'(t)};
    endfunction

    function automatic word_t enc_waith(input int t);
        return {OP_WAITH, 12'(t)};
    endfunction

    function automatic word_t enc_jump(input int a);
        return {OP_JUMP, 12'(a)};
    endfunction

    // walk the shadow program from 0 and queue the writes of one frame
    // earliest and latest bound the raster position of each write
    function automatic void predict_frame();
        logic [7:0] pc;
        int         lo;
        int         hi;
        int         met;
        int         t;
        word_t      w;
        exp_t       e;
        pc = '0;
        lo = 0;
        hi = 0;
        for (int step = 0; step < 64; step++) begin
            w = shadow[pc];
            t = int'(w[11:0]);
            case (w[15:12])
                OP_WAITV: begin
                    met = (lo > t * H_TOTAL) ? lo : t * H_TOTAL;
                    lo = met;
                    hi = (hi + 2 > met) ? hi + 2 : met;
                    pc = pc + 8'd1;
                end
                OP_WAITH: begin
                    // target on the line the engine is on
                    met = (lo % H_TOTAL >= t) ? lo : (lo / H_TOTAL) * H_TOTAL + t;
                    lo = met;
                    hi = (hi + 2 > met) ? hi + 2 : met;
                    pc = pc + 8'd1;
                end
                OP_MOVE: begin
                    // fetch, data read and write fit in 6 cycles
                    hi = hi + 6;
                    e.addr     = w[7:0];
                    e.data     = shadow[pc + 8'd1];
                    e.earliest = lo;
                    e.latest   = hi;
                    exp_q.push_back(e);
                    pc = pc + 8'd2;
                end
                OP_JUMP: begin
                    hi = hi + 2;
                    pc = w[7:0];
                end
                default: return;
            endcase
        end
    endfunction

    // drive one host register write 1 ns after the rising edge
    task automatic host_write(input logic [1:0] r, input word_t d);
        @(posedge clk);
        #1;
        host_wr_i   = 1'b1;
        host_reg_i  = r;
        host_data_i = d;
        @(posedge clk);
        #1;
        host_wr_i = 1'b0;
    endtask

    task automatic set_ptr(input logic [7:0] a);
        host_write(2'd0, {8'h00, a});
        wr_ptr = a;
    endtask

    task automatic load_word(input word_t w);
        host_write(2'd1, w);
        shadow[wr_ptr] = w;
        wr_ptr = wr_ptr + 8'd1;
    endtask

    // MOVE to register r with data from the lfsr
    task automatic load_move(input logic [7:0] r);
        load_word({OP_MOVE, 4'h0, r});
        load_word(next_rand_word());
    endtask

    task automatic set_enable(input logic b);
        host_write(2'd2, {15'b0, b});
        en_model = b;
    endtask

    // negedge of the cycle where both counts are zero
    task automatic wait_frame_start();
        @(negedge clk);
        while (h_count_o != '0 || v_count_o != '0) begin
            @(negedge clk);
        end
    endtask

    // close the previous frame and predict the one that starts
    task automatic next_frame();
        wait_frame_start();
        assert (exp_q.size() == 0) else begin
            $display("%0d expected register writes missing at frame end, time %0t",
                     exp_q.size(), $time);
            stop_with_failure();
        end
        if (en_model) begin
            predict_frame();
        end
    endtask

    // after the last write only a JUMP and the END fetch remain
    task automatic wait_program_idle();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
    endtask

    // compare every register write pulse against the prediction
    always @(negedge clk) begin : compare_writes
        int   pos;
        exp_t e;
        if (reg_wr_o === 1'b1) begin
            assert (exp_q.size() != 0) else begin
                $display("unexpected register write at time %0t, addr %0h data %0h",
                         $time, reg_addr_o, reg_data_o);
                stop_with_failure();
            end
            e = exp_q.pop_front();
            pos = int'(v_count_o) * H_TOTAL + int'(h_count_o);
            assert (reg_addr_o == e.addr) else begin
                $display("FAILED at %0t: reg_addr_o expected %0h, got %0h",
                         $time, e.addr, reg_addr_o);
                stop_with_failure();
            end
            assert (reg_data_o == e.data) else begin
                $display("FAILED at %0t: reg_data_o expected %0h, got %0h",
                         $time, e.data, reg_data_o);
                stop_with_failure();
            end
            assert (pos >= e.earliest && pos <= e.latest) else begin
                $display("FAILED at %0t: raster position of reg_wr_o expected %0d to %0d, got %0d",
                         $time, e.earliest, e.latest, pos);
                stop_with_failure();
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
        stop_with_failure();
    end

    initial begin
        clk         = 1'b0;
        rst_i       = 1'b1;
        host_wr_i   = 1'b0;
        host_reg_i  = 2'd0;
        host_data_i = '0;
        en_model    = 1'b0;
        wr_ptr      = '0;
        // shadow holds the END fill and the info version word
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = END_FILL;
        end
        shadow[MEM_WORDS-4] = INFO_VERSION;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_i = 1'b0;
        @(negedge clk);
        assert (h_count_o == '0 && v_count_o == '0 && reg_wr_o == 1'b0) else begin
            $display("FAILED at %0t: counts and reg_wr_o after reset expected 0, got %0d %0d %0b",
                     $time, h_count_o, v_count_o, reg_wr_o);
            stop_with_failure();
        end

        // two quiet frames while disabled
        next_frame();
        next_frame();

        // MOVE list repeated over three frames
        set_ptr(8'd0);
        for (int i = 0; i < 4; i++) begin
            load_move(8'h10 + 8'(i));
        end
        load_word(END_FILL);
        set_enable(1'b1);
        repeat (3) next_frame();
        wait_program_idle();

        // raster waits
        set_ptr(8'd0);
        load_word(enc_waitv(3));
        load_word(enc_waith(40));
        load_move(8'h20);
        load_word(enc_waitv(6));
        load_move(8'h21);
        load_word(enc_waith(20));
        load_move(8'h22);
        load_word(END_FILL);
        next_frame();
        wait_program_idle();

        // JUMP into never written memory
        set_ptr(8'd0);
        load_move(8'h28);
        load_word(enc_jump(100));
        load_move(8'h29);
        load_word(END_FILL);
        next_frame();
        wait_program_idle();

        // MOVE whose data word is the info version
        set_ptr(8'd251);
        load_word({OP_MOVE, 4'h0, 8'h30});
        set_ptr(8'd253);
        load_word(END_FILL);
        set_ptr(8'd0);
        load_word(enc_jump(251));
        next_frame();
        wait_program_idle();

        // disable between two writes and the frame still completes
        set_ptr(8'd0);
        load_word(enc_waitv(2));
        load_move(8'h40);
        load_word(enc_waitv(8));
        load_move(8'h41);
        load_word(END_FILL);
        next_frame();
        while (exp_q.size() > 1) begin
            @(negedge clk);
        end
        set_enable(1'b0);
        next_frame();
        // enable again mid-frame so writes resume at the next frame
        while (v_count_o != 12'd8) begin
            @(negedge clk);
        end
        set_enable(1'b1);
        next_frame();
        next_frame();

        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: video_timing.sv
/*
  Raster timing for the copper.
  Horizontal count advances every clock and wraps at H_TOTAL, the
  vertical count steps on each wrap and wraps at V_TOTAL.
  frame_start_o is high for the single cycle in which both counts are
  zero, and the engine uses it to restart its program.
*/
module video_timing #(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic                      clk,
    input  logic                      rst_i,
    output logic [xv_pkg::HPOS_W-1:0] h_count_o,
    output logic [xv_pkg::VPOS_W-1:0] v_count_o,
    output logic                      frame_start_o
);
    import xv_pkg::*;

    // last position of a line and of a frame
    localparam logic [HPOS_W-1:0] H_LAST = HPOS_W'(H_TOTAL - 1);
    localparam logic [VPOS_W-1:0] V_LAST = VPOS_W'(V_TOTAL - 1);

    logic h_wrap;
    logic v_wrap;

    // end of line, and end of frame on the last line
    assign h_wrap = (h_count_o == H_LAST);
    assign v_wrap = (v_count_o == V_LAST);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            h_count_o     <= '0;
            v_count_o     <= '0;
            // counts sit at the origin out of reset
            frame_start_o <= 1'b1;
        end else begin
            frame_start_o <= 1'b0;
            if (h_wrap) begin
                h_count_o <= '0;
                if (v_wrap) begin
                    v_count_o     <= '0;
                    // next cycle is position 0,0
                    frame_start_o <= 1'b1;
                end else begin
                    v_count_o <= v_count_o + 1'b1;
                end
            end else begin
                h_count_o <= h_count_o + 1'b1;
            end
        end
    end

endmodule

// File: xv_pkg.sv
/*
  Shared definitions for the copper display-list coprocessor.
  Holds the word type, the instruction encoding and the END fill word,
  plus the build information placed in the top 128 words of copper
  memory. Modules import it with xv_pkg::* in their body.
*/
package xv_pkg;

    // raster count widths
    localparam int HPOS_W = 12;
    localparam int VPOS_W = 12;

    // copper instruction word and video register word
    typedef logic [15:0] word_t;

    // opcode lives in the top nibble of an instruction
    typedef enum logic [3:0] {
        OP_WAITV = 4'd0,
        OP_WAITH = 4'd1,
        OP_END   = 4'd2,
        OP_MOVE  = 4'd3,
        OP_JUMP  = 4'd4
    } copp_op_t;

    // opcode field
    localparam int OP_MSB = 15;
    localparam int OP_LSB = 12;

    // operand widths, all start at bit 0
    // wait target for WAITV and WAITH
    localparam int WAIT_W = 12;
    // register address for MOVE
    localparam int MOVE_REG_W = 8;
    // target address for JUMP
    localparam int JUMP_W = 12;

    // END with all operand bits set, used to fill copper memory
    localparam word_t END_FILL = 16'h2FFF;

    // build info block occupies the last 128 words of memory
    localparam int INFO_WORDS = 128;

    // BCD version, major byte then minor byte
    localparam logic [15:0] INFO_VERSION = 16'h0103;

    // set when the source tree had local changes
    localparam logic INFO_GIT_DIRTY = 1'b0;

    // short commit hash
    localparam logic [31:0] INFO_GITHASH = 32'h3C0F_FEE1;

    // description string, at most 240 characters
    // length must match the literal exactly or leading bytes turn to zero
    localparam int INFO_STR_LEN = 25;
    localparam logic [8*INFO_STR_LEN-1:0] INFO_STR = "copper raster coprocessor";

endpackage
